// File: video_timing_pkg.sv
// video timing package: raster line states and default sync geometry
package video_timing_pkg;

	// horizontal line state of the TV raster
	typedef enum logic
	{
		HS_ACTIVE,
		HS_BLANK
	} h_state_t;

	// geometry in TV pixels per line
	// kept tiny so a whole frame fits a short sim run
	localparam int TV_H_TOTAL = 16;
	localparam int TV_H_ACTIVE = 12;

	// geometry in TV lines per frame
	localparam int TV_V_TOTAL = 6;
	localparam int TV_V_ACTIVE = 4;

	// one TV pixel spans two clk cycles
	// one VGA line spans TV_H_TOTAL clocks, two per TV line
	// VGA horizontal blank is TV_H_TOTAL - TV_H_ACTIVE clocks

	// raster counter widths for the defaults
	localparam int TV_H_W = $clog2(TV_H_TOTAL);
	localparam int TV_V_W = $clog2(TV_V_TOTAL);

	// blank window lengths for the defaults
	localparam int TV_H_BLANK = TV_H_TOTAL - TV_H_ACTIVE;
	localparam int TV_V_BLANK = TV_V_TOTAL - TV_V_ACTIVE;

	// clocks per TV line and per frame
	localparam int TV_LINE_CLKS = 2 * TV_H_TOTAL;
	localparam int TV_FRAME_CLKS = TV_LINE_CLKS * TV_V_TOTAL;

endpackage

// File: palette_pkg.sv
// palette package: CRAM word layout and PWM dither patterns for the 2:2:2 DAC
package palette_pkg;

	// CRAM depth 256 entries
	localparam int CRAM_AW = 8;

	// per channel field widths
	localparam int COARSE_W = 2;
	localparam int FINE_W = 3;

	// one channel: DAC level on top, dither level below
	typedef struct packed
	{
		logic [COARSE_W-1:0] coarse;
		logic [FINE_W-1:0] fine;
	} chan_t;

	// 15-bit palette word, red in the top bits
	typedef struct packed
	{
		chan_t red;
		chan_t grn;
		chan_t blu;
	} cram_word_t;

	// dither masks, row by fine level, bit by PWM phase
	// popcount of row n is n, spread over the 8 phases
	localparam logic [7:0] PWM_PATTERN [8] = '{
		8'h00, 8'h01, 8'h41, 8'h45, 8'hA5, 8'hA7, 8'hD7, 8'hDF
	};

endpackage

// File: video_ctl_if.sv
// video control interface: timing strobes from the sync generator to its consumers
interface video_ctl_if (
	input logic clk
);

	// mode level, TV when low
	logic vga_on;

	// TV pixel strobe, every second clk
	logic c6;

	// blank windows of both rasters
	logic tv_blank;
	logic vga_blank;

	// which VGA copy of the TV line is running
	logic vga_line;

	// nibble selects, bit 0 for VGA, bit 1 for TV
	logic [1:0] plex_sel;

	// generator side
	modport sync (input clk, input vga_on,
		output c6, output tv_blank, output vga_blank, output vga_line, output plex_sel);

	// scan doubler side, strobes only
	modport scan (input clk, input c6, input tv_blank, input vga_blank, input vga_line);

	// output stage side
	modport out (input clk, input vga_on, input c6, input tv_blank, input vga_blank,
		input vga_line, input plex_sel);

endinterface

// File: video_sync.sv
// video sync generator: raster counters, blank windows, pixel strobe and nibble selects
module video_sync #(
	parameter int H_TOTAL = video_timing_pkg::TV_H_TOTAL,
	parameter int H_ACTIVE = video_timing_pkg::TV_H_ACTIVE,
	parameter int V_TOTAL = video_timing_pkg::TV_V_TOTAL,
	parameter int V_ACTIVE = video_timing_pkg::TV_V_ACTIVE
) (
	input logic clk,
	input logic rst,
	video_ctl_if.sync ctl
);
	import video_timing_pkg::*;

	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);
	localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
	localparam logic [HW-1:0] H_ACT_LAST = HW'(H_ACTIVE - 1);
	localparam logic [HW-1:0] VGA_HBLANK = HW'(H_TOTAL - H_ACTIVE);
	localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);
	localparam logic [VW-1:0] V_ACT = VW'(V_ACTIVE);

	h_state_t h_state;
	logic [HW-1:0] h_cnt;
	logic [HW-1:0] hl_cnt;
	logic [VW-1:0] v_cnt;
	logic c6;
	logic vga_line;
	logic [1:0] plex_sel;
	logic tv_vblank;
	logic vga_vblank;

	// pixel strobe, half-line counter and nibble toggles run every clk
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			c6 <= 1'b1;
			hl_cnt <= '0;
			vga_line <= 1'b0;
			plex_sel <= '0;
		end
		else
		begin
			c6 <= ~c6;
			plex_sel[0] <= ~plex_sel[0];
			if (c6)
				plex_sel[1] <= ~plex_sel[1];
			// one VGA line is H_TOTAL clocks, two of them per TV line
			if (hl_cnt == H_LAST)
			begin
				hl_cnt <= '0;
				vga_line <= ~vga_line;
			end
			else
				hl_cnt <= hl_cnt + 1'b1;
		end
	end

	// TV raster moves one pixel per c6
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
			h_state <= HS_ACTIVE;
		end
		else if (c6)
		begin
			if (h_cnt == H_LAST)
			begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
			end
			else
				h_cnt <= h_cnt + 1'b1;
			case (h_state)
				HS_ACTIVE:
					if (h_cnt == H_ACT_LAST)
						h_state <= HS_BLANK;
				HS_BLANK:
					if (h_cnt == H_LAST)
						h_state <= HS_ACTIVE;
				default:
					h_state <= HS_ACTIVE;
			endcase
		end
	end

	assign tv_vblank = v_cnt >= V_ACT;
	// VGA replays the previous TV line, so its frame sits one line later
	assign vga_vblank = (v_cnt == '0) || (v_cnt > V_ACT);

	assign ctl.c6 = c6;
	assign ctl.tv_blank = (h_state == HS_BLANK) || tv_vblank;
	// hblank leads each VGA line
	assign ctl.vga_blank = (hl_cnt < VGA_HBLANK) || vga_vblank;
	assign ctl.vga_line = vga_line;
	assign ctl.plex_sel = plex_sel;

endmodule

// File: video_scandbl.sv
// scan doubler: stores each TV line and replays it twice at VGA pixel rate
module video_scandbl #(
	parameter int H_ACTIVE = video_timing_pkg::TV_H_ACTIVE
) (
	input logic clk,
	video_ctl_if.scan ctl,
	input logic [7:0] pix_in,
	output logic [7:0] pix_out
);

	localparam int AW = $clog2(H_ACTIVE + 1);

	// ping-pong line store, one bank written while the other is read
	logic [7:0] line_mem [2][H_ACTIVE];
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] wa;
	logic [AW-1:0] rd_addr;
	logic wr_bank;
	logic wbank;
	logic c6_q;
	logic vga_line_q;
	logic restart;
	logic line_start;

	// c6 high on two clocks in a row only while the sync generator restarts
	assign restart = ctl.c6 & c6_q;
	// second VGA copy ending means a new TV line
	assign line_start = vga_line_q & ~ctl.vga_line;

	// bank flips on the first clk of the line, which already carries pixel 0
	always_comb
	begin
		if (restart)
			wbank = 1'b0;
		else if (line_start)
			wbank = ~wr_bank;
		else
			wbank = wr_bank;
	end

	assign wa = restart ? '0 : wr_addr;

	always_ff @(posedge clk)
	begin
		c6_q <= ctl.c6;
		vga_line_q <= ctl.vga_line;
		wr_bank <= wbank;
		// write side, one address per active TV pixel
		if (ctl.c6 && !ctl.tv_blank)
			wr_addr <= wa + 1'b1;
		else if (ctl.tv_blank)
			wr_addr <= '0;
		// read side, one address per clk in the VGA active window
		if (ctl.vga_blank)
			rd_addr <= '0;
		else
			rd_addr <= rd_addr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (ctl.c6 && !ctl.tv_blank)
			line_mem[wbank][wa] <= pix_in;
	end

	// previous line from the other bank
	assign pix_out = line_mem[~wbank][rd_addr];

endmodule

// File: video_cram.sv
// palette RAM: 256 entries of 15 bits, CPU write port and registered video read port
module video_cram (
	input logic clk,
	input logic [palette_pkg::CRAM_AW-1:0] wr_addr,
	input palette_pkg::cram_word_t wr_data,
	input logic we,
	input logic [palette_pkg::CRAM_AW-1:0] rd_addr,
	output palette_pkg::cram_word_t q
);
	import palette_pkg::*;

	localparam int DEPTH = 2 ** CRAM_AW;

	// palette storage
	cram_word_t mem [DEPTH];

	// CPU side
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// video side, old word on a same-cycle write to this entry
	always_ff @(posedge clk)
	begin
		q <= mem[rd_addr];
	end

endmodule

// File: video_out.sv
// video output stage: stream mux, hi-res split, palette lookup and PWM dither to the DAC
module video_out (
	input logic clk,
	input logic rst,
	video_ctl_if.out ctl,
	input logic hires,
	input logic [7:0] vplex_in,
	input logic [7:0] vgaplex,
	input logic [palette_pkg::CRAM_AW-1:0] cram_addr_in,
	input palette_pkg::cram_word_t cram_data_in,
	input logic cram_we,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu
);
	import palette_pkg::*;

	logic [7:0] vplex;
	logic [7:0] plex;
	logic nib_sel;
	logic [CRAM_AW-1:0] vdata;
	logic blank;
	logic blank_q;
	logic [2:0] ph;
	logic [2:0] phase;
	logic [2:0] phase_q;
	cram_word_t vpixel;
	cram_word_t vpix;

	// one step up when this phase's mask bit is set, DAC tops out at 3
	function automatic logic [COARSE_W-1:0] dither(chan_t c, logic [2:0] p);
		logic [7:0] mask;
		mask = PWM_PATTERN[c.fine];
		if (mask[p] && (c.coarse != 2'd3))
			return c.coarse + 1'b1;
		return c.coarse;
	endfunction

	// TV index held for the whole pixel
	always_ff @(posedge clk)
	begin
		if (ctl.c6)
			vplex <= vplex_in;
	end

	assign plex = ctl.vga_on ? vgaplex : vplex;
	assign nib_sel = ctl.vga_on ? ctl.plex_sel[0] : ctl.plex_sel[1];
	// hi-res uses the top 16 entries, low nibble while select is high
	assign vdata = hires ? {4'hF, nib_sel ? plex[3:0] : plex[7:4]} : plex;
	assign blank = ctl.vga_on ? ctl.vga_blank : ctl.tv_blank;

	// free phase counter
	// VGA alternates lines, so vga_line takes the top phase bit
	assign phase = ctl.vga_on ? {ctl.vga_line, ph[1:0]} : ph;

	// blank and phase follow the CRAM read by one clk
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ph <= '0;
			phase_q <= '0;
			blank_q <= 1'b1;
		end
		else
		begin
			ph <= ph + 1'b1;
			phase_q <= phase;
			blank_q <= blank;
		end
	end

	video_cram u_video_cram (
		.clk     (clk),
		.wr_addr (cram_addr_in),
		.wr_data (cram_data_in),
		.we      (cram_we),
		.rd_addr (vdata),
		.q       (vpixel)
	);

	assign vpix = blank_q ? '0 : vpixel;

	// registered DAC levels
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end
		else
		begin
			vred <= dither(vpix.red, phase_q);
			vgrn <= dither(vpix.grn, phase_q);
			vblu <= dither(vpix.blu, phase_q);
		end
	end

endmodule

// File: video_top.sv
// video colour output top: sync generator, scan doubler and palette DAC stage
module video_top #(
	parameter int H_TOTAL = video_timing_pkg::TV_H_TOTAL,
	parameter int H_ACTIVE = video_timing_pkg::TV_H_ACTIVE,
	parameter int V_TOTAL = video_timing_pkg::TV_V_TOTAL,
	parameter int V_ACTIVE = video_timing_pkg::TV_V_ACTIVE
) (
	input logic clk,
	input logic rst,
	input logic vga_on,
	input logic hires,
	input logic [7:0] vplex_in,
	input logic [palette_pkg::CRAM_AW-1:0] cram_addr,
	input palette_pkg::cram_word_t cram_data,
	input logic cram_we,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu
);

	// doubled line stream into the output mux
	logic [7:0] vgaplex;

	video_ctl_if u_ctl (.clk(clk));

	// mode level straight from the pin
	assign u_ctl.vga_on = vga_on;

	video_sync #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE),
		.V_TOTAL  (V_TOTAL),
		.V_ACTIVE (V_ACTIVE)
	) u_video_sync (
		.clk (clk),
		.rst (rst),
		.ctl (u_ctl.sync)
	);

	video_scandbl #(
		.H_ACTIVE (H_ACTIVE)
	) u_video_scandbl (
		.clk     (clk),
		.ctl     (u_ctl.scan),
		.pix_in  (vplex_in),
		.pix_out (vgaplex)
	);

	video_out u_video_out (
		.clk          (clk),
		.rst          (rst),
		.ctl          (u_ctl.out),
		.hires        (hires),
		.vplex_in     (vplex_in),
		.vgaplex      (vgaplex),
		.cram_addr_in (cram_addr),
		.cram_data_in (cram_data),
		.cram_we      (cram_we),
		.vred         (vred),
		.vgrn         (vgrn),
		.vblu         (vblu)
	);

endmodule

// File: tb_video_top.sv
// testbench for the video colour output stage with raster and palette models and colour checks
module tb_video_top;
	timeunit 1ns;
	timeprecision 1ps;

	import video_timing_pkg::*;
	import palette_pkg::*;

	// four frames for each of seven test phases plus margin
	localparam int CYCLE_LIMIT = 7 * 4 * TV_FRAME_CLKS + 256;

	logic clk;
	logic rst;
	logic vga_on;
	logic hires;
	logic [7:0] vplex_in;
	logic [CRAM_AW-1:0] cram_addr;
	cram_word_t cram_data;
	logic cram_we;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;

	integer seed;
	int cycles;

	// reference model state
	int cyc;
	int m_rd;
	logic [7:0] m_vplex;
	cram_word_t m_mem [256];
	logic [7:0] tbuf [2][16];
	logic [5:0] exp1;
	logic [5:0] exp0;
	logic blk1;
	logic blk0;

	video_top #(
		.H_TOTAL  (TV_H_TOTAL),
		.H_ACTIVE (TV_H_ACTIVE),
		.V_TOTAL  (TV_V_TOTAL),
		.V_ACTIVE (TV_V_ACTIVE)
	) u_video_top (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.hires     (hires),
		.vplex_in  (vplex_in),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.cram_we   (cram_we),
		.vred      (vred),
		.vgrn      (vgrn),
		.vblu      (vblu)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// coarse level plus the mask bit of this phase, held at the DAC top level 3
	function automatic logic [1:0] dac_level(chan_t c, logic [2:0] p);
		logic [7:0] mask;
		logic [2:0] sum;
		mask = PWM_PATTERN[c.fine];
		sum = 3'(c.coarse) + 3'(mask[p]);
		return (sum > 3'd3) ? 2'd3 : sum[1:0];
	endfunction

	task automatic mismatch(string name, logic [5:0] got, logic [5:0] want);
		$display("** Error: %s = %h, expected %h at cycle %0d", name, got, want, cyc);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// cycle model counting clocks n since reset release
	always @(posedge clk)
	begin : model
		int n;
		int hc;
		int vc;
		int line;
		logic [3:0] hl;
		logic tvb;
		logic vgab;
		logic blk;
		logic nsel;
		logic [7:0] plex;
		logic [7:0] idx;
		logic [2:0] ph;
		cram_word_t w;
		if (rst)
		begin
			cyc = 0;
			m_rd = 0;
			m_vplex = vplex_in;
			exp1 <= '0;
			exp0 <= '0;
			blk1 <= 1'b0;
			blk0 <= 1'b0;
		end
		else
		begin
			n = cyc;
			hl = 4'(n % TV_H_TOTAL);
			hc = ((n + 1) / 2) % TV_H_TOTAL;
			vc = ((n + 1) / TV_LINE_CLKS) % TV_V_TOTAL;
			line = n / TV_LINE_CLKS;
			tvb = (hc >= TV_H_ACTIVE) || (vc >= TV_V_ACTIVE);
			// VGA frame trails the TV frame by one line
			vgab = (hl < TV_H_BLANK) || (vc == 0) || (vc > TV_V_ACTIVE);
			plex = vga_on ? tbuf[(line + 1) % 2][m_rd] : m_vplex;
			nsel = vga_on ? n[0] : 1'(((n + 1) / 2) % 2);
			idx = hires ? 8'hF0 + 8'(nsel ? plex[3:0] : plex[7:4]) : plex;
			blk = vga_on ? vgab : tvb;
			ph = vga_on ? {1'((n / TV_H_TOTAL) % 2), n[1:0]} : 3'(n % 8);
			w = m_mem[idx];
			exp1 <= {dac_level(w.red, ph), dac_level(w.grn, ph), dac_level(w.blu, ph)};
			exp0 <= exp1;
			blk1 <= blk;
			blk0 <= blk1;
			// TV pixel strobe on even clocks
			if (n % 2 == 0)
			begin
				m_vplex = vplex_in;
				if (!tvb)
					tbuf[line % 2][hc] = vplex_in;
			end
			m_rd = vgab ? 0 : m_rd + 1;
			cyc = n + 1;
		end
		// palette write lands after this cycle's read
		if (cram_we)
			m_mem[cram_addr] = cram_data;
	end

	a_vred: assert property (@(posedge clk) disable iff (rst) !blk0 |-> vred == exp0[5:4])
		else mismatch("vred", {4'h0, $sampled(vred)}, {4'h0, $sampled(exp0[5:4])});
	a_vgrn: assert property (@(posedge clk) disable iff (rst) !blk0 |-> vgrn == exp0[3:2])
		else mismatch("vgrn", {4'h0, $sampled(vgrn)}, {4'h0, $sampled(exp0[3:2])});
	a_vblu: assert property (@(posedge clk) disable iff (rst) !blk0 |-> vblu == exp0[1:0])
		else mismatch("vblu", {4'h0, $sampled(vblu)}, {4'h0, $sampled(exp0[1:0])});
	// nothing leaks out during blank
	a_blank: assert property (@(posedge clk) disable iff (rst) blk0 |-> {vred, vgrn, vblu} == '0)
		else mismatch("{vred,vgrn,vblu}", $sampled({vred, vgrn, vblu}), 6'h00);

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	// new random index every hold clocks
	task automatic run_pixels(int count, int hold);
		for (int i = 0; i < count; i++)
		begin
			if (i % hold == 0)
				vplex_in = 8'($random(seed));
			@(negedge clk);
		end
	endtask

	initial
	begin
		seed = 32'hb189e0d6;
		cycles = 0;
		rst = 1'b1;
		vga_on = 1'b0;
		hires = 1'b0;
		vplex_in = 8'h00;
		// entry 0 is written while reset holds
		cram_we = 1'b1;
		cram_addr = 8'h00;
		cram_data = 15'h2000;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// zero fine levels and indices only into written entries
		for (int i = 0; i < 256; i++)
		begin
			cram_addr = 8'(i);
			cram_data = 15'($random(seed)) & 15'h6318;
			vplex_in = 8'($unsigned($random(seed)) % (i + 1));
			@(negedge clk);
		end
		cram_we = 1'b0;
		run_pixels(64, 1);

		// every entry nonzero with random fine levels and the top entry saturated
		cram_we = 1'b1;
		for (int i = 0; i < 256; i++)
		begin
			cram_addr = 8'(i);
			cram_data = (i == 255) ? 15'h7FFF : (15'($random(seed)) | 15'h4210);
			if (i % 8 == 0)
				vplex_in = 8'($random(seed));
			@(negedge clk);
		end
		cram_we = 1'b0;
		vplex_in = 8'hFF;
		repeat (16) @(negedge clk);
		run_pixels(384, 16);

		// hi-res in TV mode
		hires = 1'b1;
		run_pixels(TV_FRAME_CLKS, 1);

		// scan doubled VGA
		hires = 1'b0;
		vga_on = 1'b1;
		run_pixels(3 * TV_FRAME_CLKS, 2);
		hires = 1'b1;
		run_pixels(TV_FRAME_CLKS, 2);

		// rewrite the entry on screen
		vga_on = 1'b0;
		hires = 1'b0;
		vplex_in = 8'h37;
		cram_addr = 8'h37;
		for (int i = 0; i < 64; i++)
		begin
			cram_we = (i % 4 == 0);
			cram_data = 15'($random(seed));
			@(negedge clk);
		end
		cram_we = 1'b0;
		repeat (4) @(negedge clk);

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: verilog.f
video_timing_pkg.sv
palette_pkg.sv
video_ctl_if.sv
video_sync.sv
video_scandbl.sv
video_cram.sv
video_out.sv
video_top.sv
tb_video_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_video_top
BUILD_DIR ?= obj_dir
FILELIST ?= verilog.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
